/* hw/soc_map_pkg.sv */
// Peripheral subsystem address map
// slot select, register word indices and host bus widths
// shared by the bus decoder and every peripheral
`default_nettype none

package soc_map_pkg;

  ////////////////////////////////////////////////////////////
  // host bus geometry
  localparam int BUS_ADDR_W = 12;
  localparam int BUS_DATA_W = 32;
  // word index comes from byte address bits 7..2
  localparam int REG_IDX_W = 6;
  // slot field is the top nibble, address bits 11..8
  localparam int SLOT_W = 4;

  // peripheral slots
  localparam logic [SLOT_W-1:0] SLOT_GPIO  = 4'd0;
  localparam logic [SLOT_W-1:0] SLOT_TIMER = 4'd1;
  localparam logic [SLOT_W-1:0] SLOT_IRQ   = 4'd2;

  // read data for empty slots
  localparam logic [BUS_DATA_W-1:0] UNMAPPED_DATA = 32'hDEAD_BEEF;

  ////////////////////////////////////////////////////////////
  // gpio word indices
  localparam logic [REG_IDX_W-1:0] GPIO_REG_IN  = 6'd0;
  localparam logic [REG_IDX_W-1:0] GPIO_REG_OUT = 6'd1;
  localparam logic [REG_IDX_W-1:0] GPIO_REG_DIR = 6'd2;
  localparam logic [REG_IDX_W-1:0] GPIO_REG_IE  = 6'd3;
  localparam logic [REG_IDX_W-1:0] GPIO_REG_IP  = 6'd4;

  // timer word indices, low half first
  localparam logic [REG_IDX_W-1:0] TMR_REG_TIME_LO = 6'd0;
  localparam logic [REG_IDX_W-1:0] TMR_REG_TIME_HI = 6'd1;
  localparam logic [REG_IDX_W-1:0] TMR_REG_CMP_LO  = 6'd2;
  localparam logic [REG_IDX_W-1:0] TMR_REG_CMP_HI  = 6'd3;

  // interrupt controller word indices
  localparam logic [REG_IDX_W-1:0] IRQ_REG_PEND  = 6'd0;
  localparam logic [REG_IDX_W-1:0] IRQ_REG_EN    = 6'd1;
  localparam logic [REG_IDX_W-1:0] IRQ_REG_CLAIM = 6'd2;

endpackage

`default_nettype wire

/* hw/soc_irq_pkg.sv */
// Interrupt source numbering for the peripheral subsystem
// also carries the gpio pin count, since it sets the gpio
// interrupt width
`default_nettype none

package soc_irq_pkg;

  // gpio pins
  localparam int GPIO_WIDTH = 12;

  // outside interrupt lines
  localparam int EXT_IRQ_W = 4;

  ////////////////////////////////////////////////////////////
  // source slots of the interrupt controller
  // slot 0 means no interrupt and never pends
  localparam int IRQ_SOURCES = 6;
  localparam int IRQ_ID_W = 3;

  // gpio summary interrupt
  localparam int IRQ_SRC_GPIO = 1;
  // outside line k lands on id IRQ_SRC_EXT0 + k
  localparam int IRQ_SRC_EXT0 = 2;

endpackage

`default_nettype wire

/* hw/periph_bus_if.sv */
// Peripheral register bus
// one instance per peripheral between the decoder and the device;
// the decoder drives strobes and index, the device returns rdata
`timescale 1ns/1ps
`default_nettype none

interface periph_bus_if;
  import soc_map_pkg::*;

  // slot select from address decode
  logic                  sel;
  // write and read strobes, never both high
  logic                  we;
  logic                  re;
  // register word index
  logic [REG_IDX_W-1:0]  idx;
  logic [BUS_DATA_W-1:0] wdata;
  // combinational read data for the current idx
  logic [BUS_DATA_W-1:0] rdata;

  // decoder side
  modport host (output sel, we, re, idx, wdata, input rdata);

  // peripheral side
  modport dev (input sel, we, re, idx, wdata, output rdata);

endinterface

`default_nettype wire

/* hw/bus_decoder.sv */
// Host bus decoder
// splits the plain host strobes into one register bus per
// peripheral and registers the read return, one cycle of latency
// with a valid strobe and no back-pressure
`timescale 1ns/1ps
`default_nettype none

module bus_decoder (
  input  wire logic                              i_clk,
  input  wire logic                              i_rst,
  input  wire logic                              i_bus_we,
  input  wire logic                              i_bus_re,
  input  wire logic [soc_map_pkg::BUS_ADDR_W-1:0] i_bus_addr,
  input  wire logic [soc_map_pkg::BUS_DATA_W-1:0] i_bus_wdata,
  output logic      [soc_map_pkg::BUS_DATA_W-1:0] o_bus_rdata,
  output logic                                   o_bus_rvalid,
  periph_bus_if.host                             gpio_bus,
  periph_bus_if.host                             tmr_bus,
  periph_bus_if.host                             irq_bus
);
  import soc_map_pkg::*;

  logic [SLOT_W-1:0]     slot;
  logic [REG_IDX_W-1:0]  idx;
  logic [BUS_DATA_W-1:0] rd_mux;

  ////////////////////////////////////////////////////////////
  // address split, slot on top and word index below
  assign slot = i_bus_addr[BUS_ADDR_W-1 -: SLOT_W];
  // byte offset bits 1..0 are ignored
  assign idx  = i_bus_addr[REG_IDX_W+1:2];

  // one-hot select per slot
  assign gpio_bus.sel = (slot == SLOT_GPIO);
  assign tmr_bus.sel  = (slot == SLOT_TIMER);
  assign irq_bus.sel  = (slot == SLOT_IRQ);

  // strobes and data go to everyone, sel qualifies them
  assign gpio_bus.we    = i_bus_we;
  assign gpio_bus.re    = i_bus_re;
  assign gpio_bus.idx   = idx;
  assign gpio_bus.wdata = i_bus_wdata;

  assign tmr_bus.we    = i_bus_we;
  assign tmr_bus.re    = i_bus_re;
  assign tmr_bus.idx   = idx;
  assign tmr_bus.wdata = i_bus_wdata;

  assign irq_bus.we    = i_bus_we;
  assign irq_bus.re    = i_bus_re;
  assign irq_bus.idx   = idx;
  assign irq_bus.wdata = i_bus_wdata;

  ////////////////////////////////////////////////////////////
  // read return
  always_comb
  begin
    if (gpio_bus.sel)
      rd_mux = gpio_bus.rdata;
    else if (tmr_bus.sel)
      rd_mux = tmr_bus.rdata;
    else if (irq_bus.sel)
      rd_mux = irq_bus.rdata;
    else
      rd_mux = UNMAPPED_DATA;
  end

  // valid follows the read request by exactly one cycle
  always_ff @(posedge i_clk)
  begin
    if (i_rst)
      o_bus_rvalid <= 1'b0;
    else
      o_bus_rvalid <= i_bus_re;
  end

  // data is only loaded on a read, holds otherwise
  always_ff @(posedge i_clk)
  begin
    if (i_bus_re)
      o_bus_rdata <= rd_mux;
  end

endmodule

`default_nettype wire

/* hw/gpio_ctrl.sv */
// GPIO controller
// output and direction registers, two-flop input synchronizer
// and per-pin rising-edge interrupts with write-one-to-clear
// pending bits
`timescale 1ns/1ps
`default_nettype none

module gpio_ctrl (
  input  wire logic                              i_clk,
  input  wire logic                              i_rst,
  periph_bus_if.dev                              bus,
  input  wire logic [soc_irq_pkg::GPIO_WIDTH-1:0] i_gpio,
  output logic      [soc_irq_pkg::GPIO_WIDTH-1:0] o_gpio,
  output logic      [soc_irq_pkg::GPIO_WIDTH-1:0] o_gpio_dir,
  output logic                                   o_irq
);
  import soc_map_pkg::*;
  import soc_irq_pkg::*;

  logic [GPIO_WIDTH-1:0] sync1;
  logic [GPIO_WIDTH-1:0] sync2;
  logic [GPIO_WIDTH-1:0] in_prev;
  logic [GPIO_WIDTH-1:0] ie;
  logic [GPIO_WIDTH-1:0] ip;
  logic [GPIO_WIDTH-1:0] rise;
  logic [GPIO_WIDTH-1:0] ip_clr;
  logic                  wr;

  assign wr = bus.sel && bus.we;

  ////////////////////////////////////////////////////////////
  // input path
  // sync2 is the pin value seen by software
  // in_prev is one edge behind, for edge detect
  always_ff @(posedge i_clk)
  begin
    if (i_rst)
    begin
      sync1   <= '0;
      sync2   <= '0;
      in_prev <= '0;
    end
    else
    begin
      sync1   <= i_gpio;
      sync2   <= sync1;
      in_prev <= sync2;
    end
  end

  assign rise = sync2 & ~in_prev;

  // write-one-to-clear mask
  assign ip_clr = (wr && bus.idx == GPIO_REG_IP) ? bus.wdata[GPIO_WIDTH-1:0] : '0;

  ////////////////////////////////////////////////////////////
  // control registers
  always_ff @(posedge i_clk)
  begin
    if (i_rst)
    begin
      o_gpio     <= '0;
      o_gpio_dir <= '0;
      ie         <= '0;
      ip         <= '0;
    end
    else
    begin
      if (wr && bus.idx == GPIO_REG_OUT)
        o_gpio <= bus.wdata[GPIO_WIDTH-1:0];
      if (wr && bus.idx == GPIO_REG_DIR)
        o_gpio_dir <= bus.wdata[GPIO_WIDTH-1:0];
      if (wr && bus.idx == GPIO_REG_IE)
        ie <= bus.wdata[GPIO_WIDTH-1:0];
      // a new edge wins over a clear in the same cycle
      ip <= (ip & ~ip_clr) | rise;
    end
  end

  // summary interrupt, masked pending pins
  assign o_irq = |(ip & ie);

  // register readback, zero extended
  always_comb
  begin
    bus.rdata = '0;
    case (bus.idx)
      GPIO_REG_IN:  bus.rdata[GPIO_WIDTH-1:0] = sync2;
      GPIO_REG_OUT: bus.rdata[GPIO_WIDTH-1:0] = o_gpio;
      GPIO_REG_DIR: bus.rdata[GPIO_WIDTH-1:0] = o_gpio_dir;
      GPIO_REG_IE:  bus.rdata[GPIO_WIDTH-1:0] = ie;
      GPIO_REG_IP:  bus.rdata[GPIO_WIDTH-1:0] = ip;
      default:      bus.rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

/* hw/mtimer.sv */
// Machine timer
// free-running 64-bit mtime and a 64-bit mtimecmp, each written
// one 32-bit half at a time; o_mtip is high while mtime has
// reached mtimecmp
`timescale 1ns/1ps
`default_nettype none

module mtimer (
  input  wire logic i_clk,
  input  wire logic i_rst,
  periph_bus_if.dev bus,
  output logic      o_mtip
);
  import soc_map_pkg::*;

  logic [2*BUS_DATA_W-1:0] mtime;
  logic [2*BUS_DATA_W-1:0] mtimecmp;
  logic                    wr;

  assign wr = bus.sel && bus.we;

  ////////////////////////////////////////////////////////////
  // time counter
  // a half write replaces the increment for that cycle
  always_ff @(posedge i_clk)
  begin
    if (i_rst)
      mtime <= '0;
    else if (wr && bus.idx == TMR_REG_TIME_LO)
      mtime[BUS_DATA_W-1:0] <= bus.wdata;
    else if (wr && bus.idx == TMR_REG_TIME_HI)
      mtime[2*BUS_DATA_W-1:BUS_DATA_W] <= bus.wdata;
    else
      mtime <= mtime + 1'b1;
  end

  // compare register, all ones keeps mtip low after reset
  always_ff @(posedge i_clk)
  begin
    if (i_rst)
      mtimecmp <= '1;
    else if (wr && bus.idx == TMR_REG_CMP_LO)
      mtimecmp[BUS_DATA_W-1:0] <= bus.wdata;
    else if (wr && bus.idx == TMR_REG_CMP_HI)
      mtimecmp[2*BUS_DATA_W-1:BUS_DATA_W] <= bus.wdata;
  end

  // level interrupt, stays up until cmp moves past time
  assign o_mtip = (mtime >= mtimecmp);

  // readback
  always_comb
  begin
    case (bus.idx)
      TMR_REG_TIME_LO: bus.rdata = mtime[BUS_DATA_W-1:0];
      TMR_REG_TIME_HI: bus.rdata = mtime[2*BUS_DATA_W-1:BUS_DATA_W];
      TMR_REG_CMP_LO:  bus.rdata = mtimecmp[BUS_DATA_W-1:0];
      TMR_REG_CMP_HI:  bus.rdata = mtimecmp[2*BUS_DATA_W-1:BUS_DATA_W];
      default:         bus.rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

/* hw/irq_ctrl.sv */
// External interrupt controller
// latches source levels into pending bits, masks them with an
// enable register and hands out the lowest enabled pending id
// on a claim read; the claim clears that pending bit
`timescale 1ns/1ps
`default_nettype none

module irq_ctrl (
  input  wire logic                               i_clk,
  input  wire logic                               i_rst,
  periph_bus_if.dev                               bus,
  input  wire logic [soc_irq_pkg::IRQ_SOURCES-1:0] i_src,
  output logic                                    o_irq
);
  import soc_map_pkg::*;
  import soc_irq_pkg::*;

  logic [IRQ_SOURCES-1:0] pend;
  logic [IRQ_SOURCES-1:0] en;
  logic [IRQ_SOURCES-1:0] active;
  logic [IRQ_SOURCES-1:0] clr_mask;
  logic [IRQ_ID_W-1:0]    claim_id;
  logic                   claim_rd;

  assign active = pend & en;

  ////////////////////////////////////////////////////////////
  // claim arbitration
  // scan from the top so the lowest id is the last to win
  always_comb
  begin
    claim_id = '0;
    for (int i = IRQ_SOURCES - 1; i > 0; i--)
    begin
      if (active[i])
        claim_id = IRQ_ID_W'(i);
    end
  end

  // claim happens on the read strobe itself
  assign claim_rd = bus.sel && bus.re && (bus.idx == IRQ_REG_CLAIM);

  // id 0 is no claim, nothing to clear
  always_comb
  begin
    clr_mask = '0;
    if (claim_rd && claim_id != '0)
      clr_mask[claim_id] = 1'b1;
  end

  ////////////////////////////////////////////////////////////
  // pending and enable
  always_ff @(posedge i_clk)
  begin
    if (i_rst)
    begin
      pend <= '0;
      en   <= '0;
    end
    else
    begin
      // clear wins this edge, a held source pends again next edge
      pend    <= (pend | i_src) & ~clr_mask;
      // slot 0 never pends
      pend[0] <= 1'b0;
      if (bus.sel && bus.we && bus.idx == IRQ_REG_EN)
        en <= bus.wdata[IRQ_SOURCES-1:0];
    end
  end

  assign o_irq = |active;

  // readback, claim read returns the id about to be cleared
  always_comb
  begin
    bus.rdata = '0;
    case (bus.idx)
      IRQ_REG_PEND:  bus.rdata[IRQ_SOURCES-1:0] = pend;
      IRQ_REG_EN:    bus.rdata[IRQ_SOURCES-1:0] = en;
      IRQ_REG_CLAIM: bus.rdata[IRQ_ID_W-1:0] = claim_id;
      default:       bus.rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

/* hw/periph_soc.sv */
// Peripheral subsystem top level
// host register bus decoder feeding gpio, machine timer and
// external interrupt controller; gpio and outside lines are
// routed into the interrupt controller, the timer goes straight out
`timescale 1ns/1ps
`default_nettype none

module periph_soc (
  input  wire logic                              i_clk,
  input  wire logic                              i_rst,
  // host register bus
  input  wire logic                              i_bus_we,
  input  wire logic                              i_bus_re,
  input  wire logic [soc_map_pkg::BUS_ADDR_W-1:0] i_bus_addr,
  input  wire logic [soc_map_pkg::BUS_DATA_W-1:0] i_bus_wdata,
  output logic      [soc_map_pkg::BUS_DATA_W-1:0] o_bus_rdata,
  output logic                                   o_bus_rvalid,
  // pins and interrupts
  input  wire logic [soc_irq_pkg::GPIO_WIDTH-1:0] i_gpio,
  input  wire logic [soc_irq_pkg::EXT_IRQ_W-1:0]  i_ext_irq,
  output logic      [soc_irq_pkg::GPIO_WIDTH-1:0] o_gpio,
  output logic      [soc_irq_pkg::GPIO_WIDTH-1:0] o_gpio_dir,
  output logic                                   o_irq,
  output logic                                   o_mtip
);
  import soc_irq_pkg::*;

  logic                   w_irq_gpio;
  logic [IRQ_SOURCES-1:0] wb_irq_src;

  periph_bus_if gpio_bus ();
  periph_bus_if tmr_bus ();
  periph_bus_if irq_bus ();

  ////////////////////////////////////////////////////////////
  // input side, address decode and read return
  bus_decoder decoder0 (
    .i_clk,
    .i_rst,
    .i_bus_we,
    .i_bus_re,
    .i_bus_addr,
    .i_bus_wdata,
    .o_bus_rdata,
    .o_bus_rvalid,
    .gpio_bus (gpio_bus.host),
    .tmr_bus  (tmr_bus.host),
    .irq_bus  (irq_bus.host)
  );

  ////////////////////////////////////////////////////////////
  // peripherals
  gpio_ctrl gpio0 (
    .i_clk,
    .i_rst,
    .bus        (gpio_bus.dev),
    .i_gpio,
    .o_gpio,
    .o_gpio_dir,
    .o_irq      (w_irq_gpio)
  );

  // core-local style timer, mtip goes to the core, not the controller
  mtimer mtimer0 (
    .i_clk,
    .i_rst,
    .bus    (tmr_bus.dev),
    .o_mtip
  );

  irq_ctrl irq0 (
    .i_clk,
    .i_rst,
    .bus   (irq_bus.dev),
    .i_src (wb_irq_src),
    .o_irq
  );

  // source vector, slot 0 tied low
  always_comb
  begin
    wb_irq_src = '0;
    wb_irq_src[IRQ_SRC_GPIO] = w_irq_gpio;
    wb_irq_src[IRQ_SRC_EXT0 +: EXT_IRQ_W] = i_ext_irq;
  end

endmodule

`default_nettype wire

/* bench/periph_soc_tb.sv */
// Testbench for the peripheral subsystem
// drives the host register bus and the pins on falling edges,
// checks gpio, interrupt claim, machine timer and read timing
// against reference models
`timescale 1ns/1ps
`default_nettype none

module periph_soc_tb;
  import soc_map_pkg::*;
  import soc_irq_pkg::*;

  localparam int WATCHDOG_CYCLES = 2000;

  logic                   i_clk;
  logic                   i_rst;
  logic                   i_bus_we;
  logic                   i_bus_re;
  logic [BUS_ADDR_W-1:0]  i_bus_addr;
  logic [BUS_DATA_W-1:0]  i_bus_wdata;
  logic [BUS_DATA_W-1:0]  o_bus_rdata;
  logic                   o_bus_rvalid;
  logic [GPIO_WIDTH-1:0]  i_gpio;
  logic [EXT_IRQ_W-1:0]   i_ext_irq;
  logic [GPIO_WIDTH-1:0]  o_gpio;
  logic [GPIO_WIDTH-1:0]  o_gpio_dir;
  logic                   o_irq;
  logic                   o_mtip;

  // bookkeeping
  int          errors;
  int          checks;
  int          tests_done;
  int          test_start_errors;

  // scratch values shared by the tests
  logic [BUS_DATA_W-1:0]  rd;
  logic [BUS_DATA_W-1:0]  rd2;
  logic [BUS_DATA_W-1:0]  wd;
  logic [BUS_DATA_W-1:0]  exp_w;
  logic [BUS_DATA_W-1:0]  rnd;
  logic [BUS_DATA_W-1:0]  hi_v;
  logic [GPIO_WIDTH-1:0]  gpio_old;
  logic [GPIO_WIDTH-1:0]  gpio_new;
  logic [GPIO_WIDTH-1:0]  gpio_ie;
  logic [GPIO_WIDTH-1:0]  gpio_ip;
  logic [GPIO_WIDTH-1:0]  gpio_out_last;
  logic [IRQ_SOURCES-1:0] pend_m;
  logic [IRQ_SOURCES-1:0] src_m;
  logic [IRQ_SOURCES-1:0] en_v;
  logic [IRQ_ID_W-1:0]    id;
  logic [BUS_ADDR_W-1:0]  burst_addr [4];
  logic [BUS_DATA_W-1:0]  burst_exp [4];
  logic                   drained;
  int                     wait_n;

  periph_soc i_periph_soc (
    .i_clk,
    .i_rst,
    .i_bus_we,
    .i_bus_re,
    .i_bus_addr,
    .i_bus_wdata,
    .o_bus_rdata,
    .o_bus_rvalid,
    .i_gpio,
    .i_ext_irq,
    .o_gpio,
    .o_gpio_dir,
    .o_irq,
    .o_mtip
  );

  // 100 ns clock
  always #50 i_clk = ~i_clk;

  ////////////////////////////////////////////////////////////
  // reference models

  // byte address of a register word
  function automatic logic [BUS_ADDR_W-1:0] reg_addr(input logic [SLOT_W-1:0] slot,
                                                      input logic [REG_IDX_W-1:0] idx);
    return {slot, idx, 2'b00};
  endfunction

  // lowest enabled pending id or 0 for none
  function automatic logic [IRQ_ID_W-1:0] exp_claim(input logic [IRQ_SOURCES-1:0] pend,
                                                     input logic [IRQ_SOURCES-1:0] en);
    for (int i = 1; i < IRQ_SOURCES; i++)
    begin
      if (pend[i] && en[i])
        return i[IRQ_ID_W-1:0];
    end
    return '0;
  endfunction

  // pins that went from low to high
  function automatic logic [GPIO_WIDTH-1:0] exp_edge_pending(input logic [GPIO_WIDTH-1:0] old_v,
                                                             input logic [GPIO_WIDTH-1:0] new_v);
    return new_v & ~old_v;
  endfunction

  ////////////////////////////////////////////////////////////
  // compare tasks
  task automatic check_word(input logic [BUS_DATA_W-1:0] got,
                            input logic [BUS_DATA_W-1:0] expv, input string msg);
    checks++;
    if (got !== expv)
    begin
      errors++;
      $display("Fail at %0t ns: %s, got %h expected %h", $time, msg, got, expv);
    end
  endtask

  task automatic check_gpio(input logic [GPIO_WIDTH-1:0] got,
                            input logic [GPIO_WIDTH-1:0] expv, input string msg);
    checks++;
    if (got !== expv)
    begin
      errors++;
      $display("Fail at %0t ns: %s, got %h expected %h", $time, msg, got, expv);
    end
  endtask

  task automatic check_bit(input logic got, input logic expv, input string msg);
    checks++;
    if (got !== expv)
    begin
      errors++;
      $display("Fail at %0t ns: %s, got %b expected %b", $time, msg, got, expv);
    end
  endtask

  task automatic finish_test(input string name);
    $display("test %-14s done, %0d errors", name, errors - test_start_errors);
    tests_done++;
    test_start_errors = errors;
  endtask

  ////////////////////////////////////////////////////////////
  // host bus
  // write lands on the rising edge inside the strobe cycle
  task automatic bus_write(input logic [BUS_ADDR_W-1:0] addr,
                           input logic [BUS_DATA_W-1:0] data);
    @(negedge i_clk);
    i_bus_we    = 1'b1;
    i_bus_addr  = addr;
    i_bus_wdata = data;
    @(negedge i_clk);
    i_bus_we = 1'b0;
  endtask

  // one cycle strobe, then wait for the valid strobe
  task automatic bus_read(input logic [BUS_ADDR_W-1:0] addr,
                          output logic [BUS_DATA_W-1:0] data);
    int wait_cnt;
    @(negedge i_clk);
    i_bus_re   = 1'b1;
    i_bus_addr = addr;
    @(negedge i_clk);
    i_bus_re = 1'b0;
    wait_cnt = 0;
    while (!o_bus_rvalid && wait_cnt < 8)
    begin
      @(negedge i_clk);
      wait_cnt++;
    end
    if (!o_bus_rvalid)
    begin
      errors++;
      $display("read of address %h never returned a valid strobe", addr);
    end
    data = o_bus_rdata;
  endtask

  // watchdog over the whole run
  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge i_clk);
    $display("timeout: tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // main sequence
  initial
  begin
    rnd = $urandom(32'hda1a);
    errors = 0;
    checks = 0;
    tests_done = 0;
    test_start_errors = 0;
    i_clk = 1'b0;
    i_rst = 1'b1;
    i_bus_we = 1'b0;
    i_bus_re = 1'b0;
    i_bus_addr = '0;
    i_bus_wdata = '0;
    i_gpio = '0;
    i_ext_irq = '0;
    repeat (2) @(posedge i_clk);
    @(negedge i_clk);
    i_rst = 1'b0;

    // gpio output and direction readback
    for (int i = 0; i < 4; i++)
    begin
      wd = $urandom;
      rnd = $urandom;
      bus_write(reg_addr(SLOT_GPIO, GPIO_REG_OUT), wd);
      bus_write(reg_addr(SLOT_GPIO, GPIO_REG_DIR), rnd);
      gpio_out_last = wd[GPIO_WIDTH-1:0];
      check_gpio(o_gpio, wd[GPIO_WIDTH-1:0], "gpio output pins");
      check_gpio(o_gpio_dir, rnd[GPIO_WIDTH-1:0], "gpio direction pins");
      bus_read(reg_addr(SLOT_GPIO, GPIO_REG_OUT), rd);
      exp_w = '0;
      exp_w[GPIO_WIDTH-1:0] = wd[GPIO_WIDTH-1:0];
      check_word(rd, exp_w, "gpio output readback");
      bus_read(reg_addr(SLOT_GPIO, GPIO_REG_DIR), rd);
      exp_w[GPIO_WIDTH-1:0] = rnd[GPIO_WIDTH-1:0];
      check_word(rd, exp_w, "gpio direction readback");
    end
    finish_test("gpio_output");

    // gpio input sync and edge interrupts seen through irq_ctrl
    wd = '0;
    wd[IRQ_SRC_GPIO] = 1'b1;
    bus_write(reg_addr(SLOT_IRQ, IRQ_REG_EN), wd);
    rnd = $urandom;
    gpio_ie = rnd[GPIO_WIDTH-1:0] | 12'h001;
    bus_write(reg_addr(SLOT_GPIO, GPIO_REG_IE), {20'b0, gpio_ie});
    gpio_ip = '0;
    for (int i = 0; i < 4; i++)
    begin
      gpio_old = i_gpio;
      rnd = $urandom;
      gpio_new = rnd[GPIO_WIDTH-1:0];
      // first pattern always has a rise on an enabled pin
      if (i == 0)
        gpio_new[0] = 1'b1;
      @(negedge i_clk);
      i_gpio = gpio_new;
      repeat (3) @(negedge i_clk);
      gpio_ip = gpio_ip | exp_edge_pending(gpio_old, gpio_new);
      bus_read(reg_addr(SLOT_GPIO, GPIO_REG_IN), rd);
      check_word(rd, {20'b0, gpio_new}, "gpio input readback");
    end
    bus_read(reg_addr(SLOT_GPIO, GPIO_REG_IP), rd);
    check_word(rd, {20'b0, gpio_ip}, "gpio pending bits");
    check_bit(o_irq, |(gpio_ip & gpio_ie), "irq line from gpio edges");
    // write-one-to-clear, then claim the latched source
    bus_write(reg_addr(SLOT_GPIO, GPIO_REG_IP), {20'b0, gpio_ip});
    bus_read(reg_addr(SLOT_GPIO, GPIO_REG_IP), rd);
    check_word(rd, '0, "gpio pending after clear");
    pend_m = '0;
    pend_m[IRQ_SRC_GPIO] = |(gpio_ip & gpio_ie);
    en_v = '0;
    en_v[IRQ_SRC_GPIO] = 1'b1;
    bus_read(reg_addr(SLOT_IRQ, IRQ_REG_CLAIM), rd);
    exp_w = '0;
    exp_w[IRQ_ID_W-1:0] = exp_claim(pend_m, en_v);
    check_word(rd, exp_w, "gpio claim id");
    @(negedge i_clk);
    check_bit(o_irq, 1'b0, "irq line after gpio clear and claim");
    finish_test("gpio_input");

    // claim over random source and enable patterns
    pend_m = '0;
    for (int p = 0; p < 6; p++)
    begin
      rnd = $urandom;
      en_v = rnd[IRQ_SOURCES-1:0];
      wd = '0;
      wd[IRQ_SOURCES-1:0] = en_v;
      bus_write(reg_addr(SLOT_IRQ, IRQ_REG_EN), wd);
      rnd = $urandom;
      @(negedge i_clk);
      i_ext_irq = rnd[EXT_IRQ_W-1:0];
      src_m = '0;
      src_m[IRQ_SRC_EXT0 +: EXT_IRQ_W] = rnd[EXT_IRQ_W-1:0];
      repeat (2) @(negedge i_clk);
      pend_m = pend_m | src_m;
      check_bit(o_irq, |(pend_m & en_v), "irq line with sources held");
      for (int c = 0; c < 3; c++)
      begin
        bus_read(reg_addr(SLOT_IRQ, IRQ_REG_CLAIM), rd);
        id = exp_claim(pend_m, en_v);
        exp_w = '0;
        exp_w[IRQ_ID_W-1:0] = id;
        check_word(rd, exp_w, "claim id with sources held");
        // a held source pends again before the next claim
        if (id != '0)
          pend_m[id] = src_m[id];
      end
    end
    // drop every source and drain with all enables on
    @(negedge i_clk);
    i_ext_irq = '0;
    src_m = '0;
    en_v = '1;
    bus_write(reg_addr(SLOT_IRQ, IRQ_REG_EN), {26'b0, en_v});
    drained = 1'b0;
    for (int c = 0; c <= IRQ_SOURCES && !drained; c++)
    begin
      bus_read(reg_addr(SLOT_IRQ, IRQ_REG_CLAIM), rd);
      id = exp_claim(pend_m, en_v);
      exp_w = '0;
      exp_w[IRQ_ID_W-1:0] = id;
      check_word(rd, exp_w, "claim id while draining");
      pend_m[id] = 1'b0;
      drained = (rd == '0);
    end
    if (!drained)
    begin
      errors++;
      $display("claims never returned zero after all sources dropped");
    end
    check_bit(o_irq, 1'b0, "irq line after drain");
    finish_test("irq_claim");

    // machine timer
    check_bit(o_mtip, 1'b0, "mtip with reset compare value");
    bus_read(reg_addr(SLOT_TIMER, TMR_REG_TIME_LO), rd);
    bus_read(reg_addr(SLOT_TIMER, TMR_REG_TIME_LO), rd2);
    check_bit(rd2 > rd, 1'b1, "mtime strictly increasing");
    bus_read(reg_addr(SLOT_TIMER, TMR_REG_TIME_HI), hi_v);
    bus_write(reg_addr(SLOT_TIMER, TMR_REG_CMP_HI), hi_v);
    bus_read(reg_addr(SLOT_TIMER, TMR_REG_TIME_LO), rd);
    bus_write(reg_addr(SLOT_TIMER, TMR_REG_CMP_LO), rd + 32'd40);
    for (int c = 0; c < 20; c++)
    begin
      @(negedge i_clk);
      check_bit(o_mtip, 1'b0, "mtip before compare reached");
    end
    wait_n = 20;
    while (!o_mtip && wait_n < 60)
    begin
      @(negedge i_clk);
      wait_n++;
    end
    check_bit(o_mtip, 1'b1, "mtip within 60 cycles of compare write");
    finish_test("timer");

    // unmapped slot and back-to-back reads
    bus_read(reg_addr(4'd3, 6'd0), rd);
    check_word(rd, UNMAPPED_DATA, "unmapped slot read");
    burst_addr[0] = reg_addr(SLOT_GPIO, GPIO_REG_OUT);
    burst_addr[1] = reg_addr(SLOT_TIMER, TMR_REG_CMP_HI);
    burst_addr[2] = reg_addr(SLOT_IRQ, IRQ_REG_EN);
    burst_addr[3] = reg_addr(4'd3, 6'd1);
    burst_exp[0] = {20'b0, gpio_out_last};
    burst_exp[1] = hi_v;
    burst_exp[2] = {26'b0, en_v};
    burst_exp[3] = UNMAPPED_DATA;
    @(negedge i_clk);
    check_bit(o_bus_rvalid, 1'b0, "rvalid idle before burst");
    for (int k = 0; k < 4; k++)
    begin
      i_bus_re = 1'b1;
      i_bus_addr = burst_addr[k];
      @(negedge i_clk);
      check_bit(o_bus_rvalid, 1'b1, $sformatf("burst read %0d valid", k));
      check_word(o_bus_rdata, burst_exp[k], $sformatf("burst read %0d data", k));
    end
    i_bus_re = 1'b0;
    @(negedge i_clk);
    check_bit(o_bus_rvalid, 1'b0, "rvalid drops after burst");
    finish_test("bus");

    $display("%0d tests, %0d checks, %0d errors", tests_done, checks, errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* periph_soc.f */
hw/soc_map_pkg.sv
hw/soc_irq_pkg.sv
hw/periph_bus_if.sv
hw/bus_decoder.sv
hw/gpio_ctrl.sv
hw/mtimer.sv
hw/irq_ctrl.sv
hw/periph_soc.sv
bench/periph_soc_tb.sv
